// File: Bender.yml
package:
  name: sc_interpolate

sources:
  - rtl/interpPkg.sv
  - rtl/interpRegs.sv
  - rtl/cicCompFilter.sv
  - rtl/cicInterpolator.sv
  - rtl/gainScaler.sv
  - rtl/scInterpolate.sv
  - target: simulation
    files:
      - testbench/scInterpolate_props.sv
      - testbench/scInterpolateTb.sv

// File: rtl/cicCompFilter.sv
// ------------------------------
// three-tap CIC droop compensation,
// taps -1/16, 9/8, -1/16 at the sample rate
// ------------------------------
module cicCompFilter
    import interpPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    clkEn,
    input  sample_t compIn,
    output sample_t compOut
);

    sample_t dly1;                           // x[n-1], centre tap
    sample_t dly2;                           // x[n-2]

    logic signed [23:0] midTap;
    logic signed [23:0] outerSum;
    logic signed [23:0] acc;                 // result in 1/16 units

    // ------------------------------
    // tap arithmetic
    // ------------------------------
    always_comb begin
        midTap   = dly1;
        outerSum = compIn;
        outerSum = outerSum + dly2;
        // 18/16 of centre minus 1/16 of each outer tap
        acc = (midTap <<< 4) + (midTap <<< 1) - outerSum;
    end

    // ------------------------------
    // delay line and output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dly1    <= '0;
            dly2    <= '0;
            compOut <= '0;
        end else if (clkEn) begin
            dly1    <= compIn;
            dly2    <= dly1;
            compOut <= satSample(acc >>> 4);     // overshoot clips at full scale
        end
    end

endmodule

// File: rtl/cicInterpolator.sv
// ------------------------------
// three-stage CIC interpolator, combs at
// the sample rate and integrators every clock
// ------------------------------
module cicInterpolator
    import interpPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    clkEn,
    input  sample_t dIn,
    output cicAcc_t dOut
);

    cicAcc_t combDly [cicStages];            // one-sample comb memories
    cicAcc_t combTap [cicStages + 1];        // comb chain, combTap[0] is the input
    cicAcc_t integ   [cicStages];
    cicAcc_t inject;                         // zero-stuffed comb output

    // ------------------------------
    // comb chain
    // ------------------------------
    always_comb begin
        combTap[0] = dIn;                    // sign-extended into the accumulator width
        for (int i = 0; i < cicStages; i++) begin
            combTap[i + 1] = combTap[i] - combDly[i];
        end
        // only the strobe cycle carries a sample, the rest are stuffed zeros
        inject = clkEn ? combTap[cicStages] : '0;
    end

    // ------------------------------
    // comb memories and integrators
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cicStages; i++) begin
                combDly[i] <= '0;
                integ[i]   <= '0;
            end
        end else begin
            if (clkEn) begin
                for (int i = 0; i < cicStages; i++) begin
                    combDly[i] <= combTap[i];
                end
            end
            // integrators wrap, the final sum still lands in range
            integ[0] <= integ[0] + inject;
            for (int i = 1; i < cicStages; i++) begin
                integ[i] <= integ[i] + integ[i - 1];
            end
        end
    end

    // DC gain is cicRate ** (cicStages - 1)
    assign dOut = integ[cicStages - 1];

endmodule

// File: rtl/gainScaler.sv
// ------------------------------
// exponent shift and mantissa multiply,
// saturating back to 18 bits
// ------------------------------
module gainScaler
    import interpPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  cicAcc_t   dIn,
    input  gainExp_t  gainExp,
    input  gainMant_t gainMant,
    output sample_t   dOut
);

    cicAcc_t            shifted;
    sample_t            expAdj;              // after shift and first clamp
    logic signed [36:0] product;             // 18 x 19 signed

    // ------------------------------
    // shift and multiply
    // ------------------------------
    always_comb begin
        shifted = dIn >>> gainExp;
        // mantissa is unsigned, a zero msb keeps the multiply signed
        product = expAdj * $signed({1'b0, gainMant});
    end

    // ------------------------------
    // pipeline registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            expAdj <= '0;
            dOut   <= '0;
        end else begin
            expAdj <= satSample(shifted);
            dOut   <= satSample(product >>> 16);  // drop 16 fraction bits
        end
    end

endmodule

// File: rtl/interpPkg.sv
// ------------------------------
// shared widths, rate, register map and
// the sample saturation helper for the interpolator
// ------------------------------
package interpPkg;

    // ------------------------------
    // data types
    // ------------------------------
    typedef logic signed [17:0] sample_t;    // one audio/IF sample
    typedef logic [31:0]        busData_t;
    typedef logic [12:0]        busAddr_t;
    typedef logic signed [29:0] cicAcc_t;    // 18 bits plus 12 bits of growth
    typedef logic [4:0]         gainExp_t;
    typedef logic [17:0]        gainMant_t;  // 1.0 is 0x10000

    // ------------------------------
    // rate and limits
    // ------------------------------
    localparam int cicRate   = 8;            // interpolation factor
    localparam int cicStages = 3;

    localparam sample_t   sampleMax = 18'sh1ffff;
    localparam sample_t   sampleMin = -18'sh20000;
    localparam gainMant_t mantOne   = 18'h10000;

    // ------------------------------
    // register map
    // ------------------------------
    localparam logic [8:0] interpRegion = 9'h040;  // addr[12:4]

    localparam logic [3:0] regCtrl = 4'h0;
    localparam logic [3:0] regTest = 4'h1;
    localparam logic [3:0] regExp  = 4'h2;
    localparam logic [3:0] regMant = 4'h3;

    localparam int ctrlBypass   = 0;
    localparam int ctrlBypassEq = 1;
    localparam int ctrlTest     = 2;
    localparam int ctrlInvert   = 3;

    // clamp a wide signed value into sample_t
    function automatic sample_t satSample(input logic signed [47:0] v);
        if (v > sampleMax) return sampleMax;
        else if (v < sampleMin) return sampleMin;
        else return v[17:0];
    endfunction

endpackage

// File: rtl/interpRegs.sv
// ------------------------------
// interpolator register slice, byte-lane writes
// and combinational readback
// ------------------------------
module interpRegs
    import interpPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      sel,         // decoded region select
    input  logic      wr0,
    input  logic      wr1,
    input  logic      wr2,
    input  logic      wr3,
    input  busAddr_t  addr,
    input  busData_t  din,
    output busData_t  dout,
    output logic      bypass,
    output logic      bypassEq,
    output logic      test,
    output logic      invert,
    output sample_t   testValue,
    output gainExp_t  gainExp,
    output gainMant_t gainMant
);

    logic [3:0]  ctrlReg;
    logic [17:0] testReg;
    logic [4:0]  expReg;
    logic [17:0] mantReg;

    busData_t byteMask;
    busData_t rdData;

    // a byte without its strobe keeps its old contents
    function automatic busData_t mergeBytes(input busData_t cur, input busData_t wrData,
                                            input busData_t mask);
        return (cur & ~mask) | (wrData & mask);
    endfunction

    assign byteMask = {{8{wr3}}, {8{wr2}}, {8{wr1}}, {8{wr0}}};

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlReg <= '0;
            testReg <= '0;
            expReg  <= '0;
            mantReg <= mantOne;                  // unity mantissa
        end else if (sel) begin
            case (addr[3:0])
                regCtrl: ctrlReg <= 4'(mergeBytes({28'd0, ctrlReg}, din, byteMask));
                regTest: testReg <= 18'(mergeBytes({14'd0, testReg}, din, byteMask));
                regExp:  expReg  <= 5'(mergeBytes({27'd0, expReg}, din, byteMask));
                regMant: mantReg <= 18'(mergeBytes({14'd0, mantReg}, din, byteMask));
                default: ;                       // holes in the map ignore writes
            endcase
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    always_comb begin
        rdData = '0;
        case (addr[3:0])
            regCtrl: rdData = {28'd0, ctrlReg};
            regTest: rdData = {14'd0, testReg};
            regExp:  rdData = {27'd0, expReg};
            regMant: rdData = {14'd0, mantReg};
            default: rdData = '0;
        endcase
    end

    assign dout = sel ? rdData : '0;

    assign bypass    = ctrlReg[ctrlBypass];
    assign bypassEq  = ctrlReg[ctrlBypassEq];
    assign test      = ctrlReg[ctrlTest];
    assign invert    = ctrlReg[ctrlInvert];
    assign testValue = testReg;
    assign gainExp   = expReg;
    assign gainMant  = mantReg;

endmodule

// File: rtl/scInterpolate.sv
// ------------------------------
// interpolator channel top, region decode,
// inversion, CIC path and output mux
// ------------------------------
module scInterpolate
    import interpPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clkEn,
    input  logic     cs,
    input  logic     wr0,
    input  logic     wr1,
    input  logic     wr2,
    input  logic     wr3,
    input  busAddr_t addr,
    input  busData_t din,
    output busData_t dout,
    input  sample_t  dataIn,
    output sample_t  dataOut,
    output logic     clkEnOut
);

    logic      interpSel;
    logic      bypass, bypassEq, test, invert;
    sample_t   testValue;
    gainExp_t  gainExp;
    gainMant_t gainMant;

    sample_t   invertIn;
    sample_t   compOut;
    sample_t   cicIn;
    cicAcc_t   cicOut;
    sample_t   gainOut;
    logic      clkEnDly;                     // strobe one clock late for the filters
    logic      bp0, bp1;
    logic      cicClear;
    logic      cicRst;
    logic [1:0] bypassMode;

    // ------------------------------
    // bus decode and registers
    // ------------------------------
    assign interpSel = cs && (addr[12:4] == interpRegion);

    interpRegs regs (
        .clk(clk), .rst(rst), .sel(interpSel),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .bypass(bypass), .bypassEq(bypassEq), .test(test), .invert(invert),
        .testValue(testValue), .gainExp(gainExp), .gainMant(gainMant)
    );

    // ------------------------------
    // input capture and clear pulse
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            invertIn <= '0;
            cicIn    <= '0;
            clkEnDly <= 1'b0;
            bp0      <= 1'b0;
            bp1      <= 1'b0;
            cicClear <= 1'b0;
        end else begin
            clkEnDly <= clkEn;
            if (clkEn) begin
                invertIn <= invert ? -dataIn : dataIn;
                cicIn    <= bypassEq ? invertIn : compOut;
                bp0      <= bypass;
                bp1      <= bp0;
                cicClear <= bp1 && !bp0;     // one strobe period, after bypass falls
            end
        end
    end

    assign cicRst = rst || cicClear;

    // ------------------------------
    // filter chain
    // ------------------------------
    // filters step one clock after the strobe so each sees the freshly captured value
    cicCompFilter compFilter (
        .clk(clk), .rst(rst), .clkEn(clkEnDly),
        .compIn(invertIn), .compOut(compOut)
    );

    cicInterpolator cic (
        .clk(clk), .rst(cicRst), .clkEn(clkEnDly),
        .dIn(cicIn), .dOut(cicOut)
    );

    gainScaler gain (
        .clk(clk), .rst(rst), .clear(cicClear),
        .dIn(cicOut), .gainExp(gainExp), .gainMant(gainMant),
        .dOut(gainOut)
    );

    // ------------------------------
    // output mux
    // ------------------------------
    assign bypassMode = {bypassEq, bypass};

    always_ff @(posedge clk) begin
        if (rst) begin
            dataOut <= '0;
        end else if (test) begin
            dataOut <= testValue;                // test value wins over every mode
        end else begin
            case (bypassMode)
                2'b00, 2'b10: dataOut <= gainOut;
                default: begin
                    if (clkEn) begin
                        dataOut <= invertIn;     // raw sample, one strobe late
                    end
                end
            endcase
        end
    end

    assign clkEnOut = bypass ? clkEn : 1'b1;

endmodule

// File: scInterpolate.f
rtl/interpPkg.sv
rtl/interpRegs.sv
rtl/cicCompFilter.sv
rtl/cicInterpolator.sv
rtl/gainScaler.sv
rtl/scInterpolate.sv
testbench/scInterpolate_props.sv
testbench/scInterpolateTb.sv

// File: testbench/scInterpolateTb.sv
// ------------------------------
// testbench for the interpolator channel
// ------------------------------
module scInterpolateTb
    import interpPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod    = 4;
    localparam int settleClocks = 64;      // full-path settling bound
    localparam int checkClocks  = 32;
    localparam int numPhases    = 5;
    localparam int phaseClocks  = 1000;    // longest phase with margin

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        clkEn = 1'b0;
    logic        cs = 1'b0;
    logic        wr0 = 1'b0;
    logic        wr1 = 1'b0;
    logic        wr2 = 1'b0;
    logic        wr3 = 1'b0;
    busAddr_t    addr = '0;
    busData_t    din = '0;
    busData_t    dout;
    sample_t     dataIn = '0;
    sample_t     dataOut;
    logic        clkEnOut;
    logic        readCheck = 1'b0;         // seen by the bound assertions
    busData_t    readExp = '0;
    logic        dcCheck = 1'b0;
    sample_t     dcExp = '0;
    busData_t    regModel [4];             // expected register contents
    logic [31:0] rngState = 32'ha5ba_68a9;
    int          strobeCnt = 0;

    scInterpolate dut (.*);

    bind scInterpolate scInterpolateProps props (
        .clk(clk), .rst(rst), .clkEn(clkEn), .dout(dout), .dataIn(dataIn),
        .dataOut(dataOut), .clkEnOut(clkEnOut), .bypass(bypass), .test(test),
        .invert(invert), .testValue(testValue),
        .readCheck(scInterpolateTb.readCheck), .readExp(scInterpolateTb.readExp),
        .dcCheck(scInterpolateTb.dcCheck), .dcExp(scInterpolateTb.dcExp)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(negedge clk) begin
        clkEn     <= (strobeCnt == cicRate - 1);  // one strobe every cicRate clocks
        strobeCnt <= (strobeCnt == cicRate - 1) ? 0 : strobeCnt + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic busData_t fieldMask(input logic [3:0] offset);
        case (offset)
            regCtrl: return 32'h0000_000f;
            regExp:  return 32'h0000_001f;
            default: return 32'h0003_ffff;    // test value and mantissa
        endcase
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    task automatic waitClocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic busWrite(input busAddr_t a, input busData_t data, input logic [3:0] strobes);
        @(negedge clk);
        cs   = 1'b1;
        addr = a;
        din  = data;
        {wr3, wr2, wr1, wr0} = strobes;
        @(negedge clk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic writeModeled(input logic [3:0] offset, input busData_t data,
                                input logic [3:0] strobes);
        busData_t laneMask;
        laneMask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        busWrite({interpRegion, offset}, data, strobes);
        regModel[offset[1:0]] = ((regModel[offset[1:0]] & ~laneMask) | (data & laneMask))
                                & fieldMask(offset);
    endtask

    task automatic busRead(input busAddr_t a, input busData_t want);
        @(negedge clk);
        cs        = 1'b1;
        addr      = a;
        readExp   = want;
        readCheck = 1'b1;
        @(negedge clk);
        cs        = 1'b0;
        readCheck = 1'b0;
    endtask

    task automatic driveNoise(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            nextRandom(r);
            dataIn = r[17:0];                 // new sample every clock
        end
    endtask

    task automatic dcCase(input logic [3:0] ctrlVal, input gainExp_t expVal,
                          input gainMant_t mantVal, input sample_t x, input sample_t want);
        dataIn = x;
        writeModeled(regExp, 32'(expVal), 4'hf);
        writeModeled(regMant, 32'(mantVal), 4'hf);
        writeModeled(regCtrl, 32'(ctrlVal), 4'h1);
        waitClocks(settleClocks);
        dcExp   = want;
        dcCheck = 1'b1;
        waitClocks(checkClocks);
        dcCheck = 1'b0;
    endtask

    // ------------------------------
    // failure hook and watchdog
    // ------------------------------
    initial begin
        wait (dut.props.failCount != 0);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, dut.props.failSig,
                 dut.props.failGot, dut.props.failExp);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first failed check");
    end

    initial begin
        #(numPhases * phaseClocks * clkPeriod);
        $display("watchdog expired, the test sequence did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic [3:0]  off;
        logic [3:0]  strb;
        sample_t     x;
        regModel = '{32'd0, 32'd0, 32'd0, 32'(mantOne)};
        waitClocks(3);
        rst = 1'b0;
        for (int i = 0; i < 24; i++) begin
            nextRandom(r);
            off  = {2'b00, r[1:0]};
            strb = r[7:4];                    // random byte lanes
            nextRandom(r);
            writeModeled(off, r, strb);
            busRead({interpRegion, off}, regModel[off[1:0]]);
        end
        busWrite({interpRegion + 9'd1, regTest}, 32'hffff_ffff, 4'hf);  // other region
        for (int i = 0; i < 4; i++) begin
            busRead({interpRegion, 4'(i)}, regModel[i]);
        end
        busRead({interpRegion, 4'h7}, 32'd0);
        busRead({interpRegion + 9'd1, regMant}, 32'd0);
        writeModeled(regCtrl, 32'h4, 4'h1);  // test override
        repeat (6) begin
            nextRandom(r);
            writeModeled(regTest, r, 4'hf);
            waitClocks(2);
        end
        writeModeled(regCtrl, 32'h1, 4'h1);
        driveNoise(160);
        writeModeled(regCtrl, 32'h9, 4'h1);  // bypass, inverted
        driveNoise(80);
        writeModeled(regCtrl, 32'h3, 4'h1);
        driveNoise(40);
        nextRandom(r);
        x = sample_t'($signed(r[15:0]));
        dcCase(4'h0, 5'd6, mantOne, x, x);
        dcCase(4'h8, 5'd6, mantOne, x, -x);
        dcCase(4'h2, 5'd6, mantOne, x, x);
        dcCase(4'h2, 5'd6, 18'h08000, x, x >>> 1);
        dcCase(4'ha, 5'd6, mantOne, x, -x);
        writeModeled(regCtrl, 32'h1, 4'h1);  // fill the CIC with noise, then leave bypass
        driveNoise(80);
        dcCase(4'h0, 5'd6, mantOne, x, x);
        dcCase(4'h2, 5'd0, mantOne, sampleMax, sampleMax);
        dcCase(4'h0, 5'd0, mantOne, sampleMin, sampleMin);
        waitClocks(4);
        if (dut.props.failCount == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "assertion failures were recorded");
        end
    end

endmodule

// File: testbench/scInterpolate_props.sv
// ------------------------------
// bound assertions, readback, test override,
// bypass path, DC gain and clkEnOut
// ------------------------------
module scInterpolateProps
    import interpPkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     clkEn,
    input busData_t dout,
    input sample_t  dataIn,
    input sample_t  dataOut,
    input logic     clkEnOut,
    input logic     bypass,
    input logic     test,
    input logic     invert,
    input sample_t  testValue,
    input logic     readCheck,              // driven by the testbench
    input busData_t readExp,
    input logic     dcCheck,
    input sample_t  dcExp
);
    timeunit 1ns;
    timeprecision 100ps;

    int          failCount = 0;
    string       failSig;
    logic [31:0] failGot;
    logic [31:0] failExp;
    sample_t     capSample;                 // last strobe's sample after inversion
    sample_t     heldSample;                // the one before, what bypass shows
    sample_t     testHold;

    function void noteFail(input string name, input logic [31:0] got, input logic [31:0] want);
        failSig = name;
        failGot = got;
        failExp = want;
        failCount++;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            capSample <= '0;
        end else if (clkEn) begin
            capSample <= invert ? -dataIn : dataIn;
        end
        heldSample <= capSample;
        testHold   <= testValue;
    end

    readbackOk: assert property (@(posedge clk) disable iff (rst) readCheck |-> dout == readExp)
        else begin
            noteFail("dout", $sampled(dout), $sampled(readExp));
            $error("register readback does not match the written value");
        end

    testOk: assert property (@(posedge clk) disable iff (rst) test |=> dataOut == testHold)
        else begin
            noteFail("dataOut", $sampled(dataOut), $sampled(testHold));
            $error("dataOut does not follow the test value");
        end

    bypassOk: assert property (@(posedge clk) disable iff (rst)
        bypass && !test && clkEn |=> dataOut == heldSample)
        else begin
            noteFail("dataOut", $sampled(dataOut), $sampled(heldSample));
            $error("bypass output is not the previous strobe's sample");
        end

    dcGainOk: assert property (@(posedge clk) disable iff (rst) dcCheck |-> dataOut == dcExp)
        else begin
            noteFail("dataOut", $sampled(dataOut), $sampled(dcExp));
            $error("settled output differs from the DC gain rule");
        end

    clkEnOutOk: assert property (@(posedge clk) disable iff (rst)
        clkEnOut == (bypass ? clkEn : 1'b1))
        else begin
            noteFail("clkEnOut", $sampled(clkEnOut), $sampled(bypass) ? $sampled(clkEn) : 1'b1);
            $error("clkEnOut does not match the bypass setting");
        end

endmodule
